//--- rtl/ecc_sram_pkg.sv
// Shared definitions for the ECC protected SRAM bank
// Sizes, vector types and FSM state encodings
// Hsiao (39,32) SECDED check matrix with parity, encode and decode functions

package ecc_sram_pkg;

  localparam int unsigned DataWidth     = 32;
  localparam int unsigned ParityWidth   = 7;
  localparam int unsigned CodeWidth     = DataWidth + ParityWidth;
  localparam int unsigned BankWords     = 64;
  localparam int unsigned BankAddrWidth = 6;
  localparam int unsigned BeWidth       = DataWidth / 8;

  typedef logic [DataWidth-1:0]     data_t;
  typedef logic [CodeWidth-1:0]     code_t;    // Data in [31:0], check bits in [38:32]
  typedef logic [BankAddrWidth-1:0] bank_addr_t;
  typedef logic [BeWidth-1:0]       be_t;
  typedef logic [ParityWidth-1:0]   syndrome_t;
  typedef logic [1:0]               err_t;     // [0] corrected single, [1] uncorrectable

  typedef logic [DataWidth-1:0][ParityWidth-1:0] h_matrix_t;

  typedef enum logic [1:0] {
    NORMAL,
    LOAD_AND_STORE,
    UPDATE_CORRECTED_DATA
  } store_state_e;

  typedef enum logic [1:0] {
    IDLE,
    READ,
    DECODE,
    FIX
  } scrub_state_e;

  // Data columns are the weight-3 vectors in ascending order, minus the three
  // that hold bit 6 and two of bits 5..3. Rows 0..5 then have odd weight and
  // row 6 has weight 12, so inverting the data inverts check bits 0..5 only
  function automatic h_matrix_t gen_h_matrix();
    h_matrix_t   m;
    int unsigned n;
    syndrome_t   col;
    m = '0;
    n = 0;
    for (int v = 0; v < (1 << ParityWidth); v++) begin
      col = syndrome_t'(v);
      if (($countones(col) == 3) && !(col[6] && ($countones(col[5:3]) == 2)) &&
          (n < DataWidth)) begin
        m[n] = col;
        n++;
      end
    end
    return m;
  endfunction

  localparam h_matrix_t HMatrix = gen_h_matrix();

  function automatic syndrome_t secded_parity(input data_t data);
    syndrome_t parity;
    parity = '0;
    for (int i = 0; i < DataWidth; i++) begin
      parity ^= HMatrix[i] & {ParityWidth{data[i]}};
    end
    return parity;
  endfunction

  function automatic code_t secded_encode(input data_t data);
    return {secded_parity(data), data};
  endfunction

  // A syndrome that matches one column is a single error, anything else
  // nonzero is reported as uncorrectable
  function automatic void secded_decode(input code_t code, output data_t data,
                                        output err_t err);
    syndrome_t syndrome;
    logic      hit;
    data     = code[DataWidth-1:0];
    syndrome = code[CodeWidth-1:DataWidth] ^ secded_parity(data);
    hit      = ($countones(syndrome) == 1); // Check bit flipped, data is fine
    for (int i = 0; i < DataWidth; i++) begin
      if (syndrome == HMatrix[i]) begin
        data[i] = ~data[i];
        hit     = 1'b1;
      end
    end
    err[0] = hit;
    err[1] = (syndrome != '0) && !hit;
  endfunction

endpackage

//--- rtl/ecc_sram_bank.sv
// Single-port code word memory
// One cycle read latency, per-bit masked write
// Array starts all zero, which decodes as a clean word

`timescale 1ns/1ps

module ecc_sram_bank import ecc_sram_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_i,
  input  logic       we_i,
  input  bank_addr_t addr_i,
  input  code_t      wdata_i,
  input  code_t      wmask_ni,   // 1 keeps the stored bit
  output code_t      rdata_o
);

  code_t mem_q [BankWords] = '{default: '0};
  code_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[addr_i] <= (wdata_i & ~wmask_ni) | (mem_q[addr_i] & wmask_ni);
    end
  end

  // Output holds the last read word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- rtl/ecc_scrubber.sv
// Background scrubber between the bus adapter and the bank
// Adapter traffic always has priority and is forwarded in the same cycle
// One word is checked per trigger, single errors are rewritten corrected

`timescale 1ns/1ps

module ecc_scrubber import ecc_sram_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  logic       scrub_trigger_i,
  output logic       scrub_fix_o,
  output logic       scrub_uncorrectable_o,

  input  logic       adp_req_i,
  input  logic       adp_we_i,
  input  bank_addr_t adp_addr_i,
  input  code_t      adp_wdata_i,
  output code_t      adp_rdata_o,

  output logic       bank_req_o,
  output logic       bank_we_o,
  output bank_addr_t bank_addr_o,
  output code_t      bank_wdata_o,
  input  code_t      bank_rdata_i
);

  scrub_state_e state_d, state_q;

  bank_addr_t scrub_addr_d, scrub_addr_q;
  logic       pending_d, pending_q;     // Trigger seen while busy
  logic       rd_issued_q;              // Scrub read reached the bank last cycle
  logic       fix_d, fix_q;
  logic       uncorr_d, uncorr_q;
  logic       scrub_req, scrub_we;
  logic       capture_fix;
  logic       addr_hit;
  bank_addr_t next_addr;
  code_t      fix_word_q;
  data_t      scrub_data;
  err_t       scrub_err;

  // Adapter wins, scrubber fills idle cycles
  assign bank_req_o   = adp_req_i || scrub_req;
  assign bank_we_o    = adp_req_i ? adp_we_i    : scrub_we;
  assign bank_addr_o  = adp_req_i ? adp_addr_i  : scrub_addr_q;
  assign bank_wdata_o = adp_req_i ? adp_wdata_i : fix_word_q;
  assign adp_rdata_o  = bank_rdata_i;

  assign scrub_fix_o           = fix_q;
  assign scrub_uncorrectable_o = uncorr_q;

  // Adapter writing the word under inspection invalidates what was read
  assign addr_hit  = adp_req_i && adp_we_i && (adp_addr_i == scrub_addr_q);
  assign next_addr = (scrub_addr_q == bank_addr_t'(BankWords - 1)) ? '0 : scrub_addr_q + 1'b1;

  always_comb begin
    secded_decode(bank_rdata_i, scrub_data, scrub_err);
  end

  always_comb begin
    state_d      = state_q;
    scrub_addr_d = scrub_addr_q;
    pending_d    = pending_q || scrub_trigger_i;
    scrub_req    = 1'b0;
    scrub_we     = 1'b0;
    fix_d        = 1'b0;
    uncorr_d     = 1'b0;
    capture_fix  = 1'b0;
    case (state_q)
      IDLE: begin
        if (pending_q || scrub_trigger_i) begin
          pending_d = 1'b0;
          state_d   = READ;
        end
      end
      READ: begin
        scrub_req = !adp_req_i;
        state_d   = DECODE;
      end
      DECODE: begin
        if (!rd_issued_q || addr_hit) begin
          state_d = READ;               // Lost the bank or data went stale
        end else if (scrub_err[0]) begin
          capture_fix = 1'b1;
          state_d     = FIX;
        end else begin
          uncorr_d     = scrub_err[1];
          scrub_addr_d = next_addr;
          state_d      = IDLE;
        end
      end
      FIX: begin
        if (addr_hit) begin
          state_d = READ;
        end else if (!adp_req_i) begin
          scrub_req    = 1'b1;
          scrub_we     = 1'b1;
          fix_d        = 1'b1;
          scrub_addr_d = next_addr;
          state_d      = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      scrub_addr_q <= '0;
      pending_q    <= 1'b0;
      rd_issued_q  <= 1'b0;
      fix_q        <= 1'b0;
      uncorr_q     <= 1'b0;
    end else begin
      state_q      <= state_d;
      scrub_addr_q <= scrub_addr_d;
      pending_q    <= pending_d;
      rd_issued_q  <= scrub_req && !scrub_we;
      fix_q        <= fix_d;
      uncorr_q     <= uncorr_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture_fix) begin
      fix_word_q <= secded_encode(scrub_data);
    end
  end

  a_scrub_only_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    adp_req_i |-> !scrub_req)
    else $error("scrub access while the adapter holds the bank");

endmodule

//--- rtl/ecc_bus_adapter.sv
// Bus side of the ECC SRAM bank
// Full writes are encoded and stored directly
// Partial writes become a read-modify-write with a one cycle stall
// Reads are decoded and corrected, single errors are written back

`timescale 1ns/1ps

module ecc_bus_adapter import ecc_sram_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  logic       bus_req_i,
  input  logic       bus_wen_i,      // 1: read, 0: write
  input  logic [31:0] bus_add_i,
  input  be_t        bus_be_i,
  input  data_t      bus_wdata_i,
  output logic       bus_gnt_o,
  output data_t      bus_rdata_o,
  output logic       single_error_o,
  output logic       multi_error_o,

  output logic       adp_req_o,
  output logic       adp_we_o,
  output bank_addr_t adp_addr_o,
  output code_t      adp_wdata_o,
  input  code_t      adp_rdata_i
);

  store_state_e state_d, state_q;

  logic       valid_read_d, valid_read_q;
  logic       bus_accept;
  logic       writeback;     // Read at t-1 came back with a single error
  bank_addr_t bus_addr;

  // Buffers for the read-modify-write and the write-back
  bank_addr_t addr_q;
  data_t      wdata_q;
  be_t        be_q;
  data_t      corrected_q;

  data_t      rd_data;
  err_t       rd_err;
  data_t      be_bits;
  data_t      merged;

  assign bus_addr   = bus_add_i[BankAddrWidth+1:2];
  assign bus_accept = bus_req_i && bus_gnt_o;

  // Only plain reads report errors
  assign valid_read_d = bus_accept && bus_wen_i;
  assign writeback    = valid_read_q && rd_err[0];

  always_comb begin
    secded_decode(adp_rdata_i, rd_data, rd_err);
  end

  assign bus_rdata_o    = rd_data;
  assign single_error_o = rd_err[0] && valid_read_q;
  assign multi_error_o  = rd_err[1] && valid_read_q;

  // Byte merge of buffered write data over the corrected old word
  always_comb begin
    for (int b = 0; b < BeWidth; b++) begin
      be_bits[b*8 +: 8] = {8{be_q[b]}};
    end
    merged = (wdata_q & be_bits) | (rd_data & ~be_bits);
  end

  always_comb begin
    state_d     = state_q;
    bus_gnt_o   = 1'b1;
    adp_req_o   = bus_req_i;
    adp_we_o    = ~bus_wen_i;
    adp_addr_o  = bus_addr;
    adp_wdata_o = secded_encode(bus_wdata_i);
    case (state_q)
      NORMAL: begin
        if (writeback) begin
          bus_gnt_o = 1'b0;           // Hold the bus until the fix is stored
          adp_req_o = 1'b0;
          state_d   = UPDATE_CORRECTED_DATA;
        end else if (bus_req_i && !bus_wen_i && !(&bus_be_i)) begin
          adp_we_o = 1'b0;            // Fetch the old word first
          state_d  = LOAD_AND_STORE;
        end
      end
      LOAD_AND_STORE: begin
        bus_gnt_o   = 1'b0;
        adp_req_o   = 1'b1;
        adp_we_o    = 1'b1;
        adp_addr_o  = addr_q;
        adp_wdata_o = secded_encode(merged);
        state_d     = NORMAL;
      end
      UPDATE_CORRECTED_DATA: begin
        bus_gnt_o   = 1'b0;
        adp_req_o   = 1'b1;
        adp_we_o    = 1'b1;
        adp_addr_o  = addr_q;
        adp_wdata_o = secded_encode(corrected_q);
        state_d     = NORMAL;
      end
      default: state_d = NORMAL;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= NORMAL;
      valid_read_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      valid_read_q <= valid_read_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_accept) begin
      addr_q  <= bus_addr;
      wdata_q <= bus_wdata_i;
      be_q    <= bus_be_i;
    end
    if (writeback) begin
      corrected_q <= rd_data;
    end
  end

  // A stall in NORMAL follows a read accepted one cycle earlier and lasts two cycles
  a_gnt_low_writeback: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!bus_gnt_o && (state_q == NORMAL)) |->
      $past(bus_req_i && bus_gnt_o && bus_wen_i) ##2 bus_gnt_o)
    else $error("bus_gnt_o low in NORMAL without a write-back");

  a_error_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(single_error_o && multi_error_o))
    else $error("single and multi error flagged together");

endmodule

//--- rtl/ecc_sram_top.sv
// Top level of the ECC protected SRAM bank
// Bus adapter feeds the scrubber, which feeds the bank
// Fault injection mask goes straight to the bank

`timescale 1ns/1ps

module ecc_sram_top import ecc_sram_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,

  input  logic        bus_req_i,
  input  logic        bus_wen_i,
  input  logic [31:0] bus_add_i,
  input  be_t         bus_be_i,
  input  data_t       bus_wdata_i,
  output logic        bus_gnt_o,
  output data_t       bus_rdata_o,
  output logic        single_error_o,
  output logic        multi_error_o,

  input  logic        scrub_trigger_i,
  output logic        scrub_fix_o,
  output logic        scrub_uncorrectable_o,

  input  code_t       test_write_mask_ni
);

  logic       adp_req, adp_we;
  bank_addr_t adp_addr;
  code_t      adp_wdata, adp_rdata;

  logic       bank_req, bank_we;
  bank_addr_t bank_addr;
  code_t      bank_wdata, bank_rdata;

  ecc_bus_adapter i_adapter (
    .clk_i,
    .rst_ni,
    .bus_req_i,
    .bus_wen_i,
    .bus_add_i,
    .bus_be_i,
    .bus_wdata_i,
    .bus_gnt_o,
    .bus_rdata_o,
    .single_error_o,
    .multi_error_o,
    .adp_req_o   (adp_req),
    .adp_we_o    (adp_we),
    .adp_addr_o  (adp_addr),
    .adp_wdata_o (adp_wdata),
    .adp_rdata_i (adp_rdata)
  );

  ecc_scrubber i_scrubber (
    .clk_i,
    .rst_ni,
    .scrub_trigger_i,
    .scrub_fix_o,
    .scrub_uncorrectable_o,
    .adp_req_i    (adp_req),
    .adp_we_i     (adp_we),
    .adp_addr_i   (adp_addr),
    .adp_wdata_i  (adp_wdata),
    .adp_rdata_o  (adp_rdata),
    .bank_req_o   (bank_req),
    .bank_we_o    (bank_we),
    .bank_addr_o  (bank_addr),
    .bank_wdata_o (bank_wdata),
    .bank_rdata_i (bank_rdata)
  );

  ecc_sram_bank i_bank (
    .clk_i,
    .rst_ni,
    .req_i    (bank_req),
    .we_i     (bank_we),
    .addr_i   (bank_addr),
    .wdata_i  (bank_wdata),
    .wmask_ni (test_write_mask_ni),
    .rdata_o  (bank_rdata)
  );

endmodule

//--- verification/ecc_sram_tb.sv
// Testbench for the ECC protected SRAM bank
// Clock, reset, bus and scrub stimulus with a reference memory model
// Fault injection through the bank write mask
// Concurrent assertions check data, error flags, stalls and scrub results

`timescale 1ns/1ps

module ecc_sram_tb import ecc_sram_pkg::*; ();

  localparam int unsigned NumOps         = 90;
  localparam int unsigned NumScrubPasses = 2;
  localparam int unsigned TimeoutCycles  = NumOps * 40 + NumScrubPasses * 4 * BankWords;

  logic clk, rst_n;
  logic bus_req, bus_wen, bus_gnt, single_error, multi_error;
  logic [31:0] bus_add;
  be_t   bus_be;
  data_t bus_wdata, bus_rdata;
  logic  scrub_trigger, scrub_fix, scrub_uncorr;
  code_t test_mask_n;

  data_t model [BankWords];   // Reference memory
  string test_name;
  data_t exp_data;
  logic  exp_single, exp_multi, check_data, scrub_check;
  int unsigned fix_count, uncorr_count, exp_fix, exp_uncorr;

  logic read_acc, partial_acc;
  scrub_state_e scrub_state;
  bank_addr_t   scrub_addr;

  assign read_acc    = bus_req && bus_gnt && bus_wen;
  assign partial_acc = bus_req && bus_gnt && !bus_wen && (bus_be != '1);
  assign scrub_state = ecc_sram_top_inst.i_scrubber.state_q;
  assign scrub_addr  = ecc_sram_top_inst.i_scrubber.scrub_addr_q;

  ecc_sram_top ecc_sram_top_inst (
    .clk_i                 (clk),
    .rst_ni                (rst_n),
    .bus_req_i             (bus_req),
    .bus_wen_i             (bus_wen),
    .bus_add_i             (bus_add),
    .bus_be_i              (bus_be),
    .bus_wdata_i           (bus_wdata),
    .bus_gnt_o             (bus_gnt),
    .bus_rdata_o           (bus_rdata),
    .single_error_o        (single_error),
    .multi_error_o         (multi_error),
    .scrub_trigger_i       (scrub_trigger),
    .scrub_fix_o           (scrub_fix),
    .scrub_uncorrectable_o (scrub_uncorr),
    .test_write_mask_ni    (test_mask_n)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fix_count    <= 0;
      uncorr_count <= 0;
    end else begin
      if (scrub_fix) fix_count <= fix_count + 1;
      if (scrub_uncorr) uncorr_count <= uncorr_count + 1;
    end
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  a_reset_state: assert property (@(posedge clk)
    $rose(rst_n) |-> ({bus_gnt, single_error, multi_error, scrub_fix, scrub_uncorr} == 5'b10000))
    else stop_with_failure($sformatf("Fail %s: status expected 10000 actual %b", test_name,
      $sampled({bus_gnt, single_error, multi_error, scrub_fix, scrub_uncorr})));

  a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
    ($past(read_acc) && check_data) |-> (bus_rdata == exp_data))
    else stop_with_failure($sformatf("Fail %s: read data expected %h actual %h", test_name,
      exp_data, $sampled(bus_rdata)));

  a_read_flags: assert property (@(posedge clk) disable iff (!rst_n)
    $past(read_acc) |-> ({single_error, multi_error} == {exp_single, exp_multi}))
    else stop_with_failure($sformatf("Fail %s: single/multi expected %b%b actual %b%b",
      test_name, exp_single, exp_multi, $sampled(single_error), $sampled(multi_error)));

  a_partial_stall: assert property (@(posedge clk) disable iff (!rst_n)
    $past(partial_acc) |-> !bus_gnt)
    else stop_with_failure($sformatf("Fail %s: bus_gnt_o after partial write expected 0 actual %b",
      test_name, $sampled(bus_gnt)));

  a_partial_release: assert property (@(posedge clk) disable iff (!rst_n)
    $past(partial_acc, 2) |-> bus_gnt)
    else stop_with_failure($sformatf("Fail %s: bus_gnt_o after stall expected 1 actual %b",
      test_name, $sampled(bus_gnt)));

  // Write-back holds the bus in the flag cycle and the cycle after
  a_writeback_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (single_error || $past(single_error)) |-> !bus_gnt)
    else stop_with_failure($sformatf("Fail %s: bus_gnt_o in write-back expected 0 actual %b",
      test_name, $sampled(bus_gnt)));

  a_scrub_counts: assert property (@(posedge clk) disable iff (!rst_n)
    scrub_check |-> (fix_count == exp_fix) && (uncorr_count == exp_uncorr))
    else stop_with_failure($sformatf("Fail %s: fix/uncorrectable expected %0d/%0d actual %0d/%0d",
      test_name, exp_fix, exp_uncorr, $sampled(fix_count), $sampled(uncorr_count)));

  a_scrub_wrap: assert property (@(posedge clk) disable iff (!rst_n)
    scrub_check |-> (scrub_addr == '0))
    else stop_with_failure($sformatf("Fail %s: scrub address expected 0 actual %0d",
      test_name, $sampled(scrub_addr)));

  task automatic wait_grant();
    logic granted;
    do begin
      @(negedge clk);
      granted = bus_gnt;   // Stable mid cycle
      @(posedge clk);
    end while (!granted);
    #1;
  endtask

  task automatic write_word(input bank_addr_t addr, input data_t data, input be_t be,
                            input code_t mask_n);
    bus_req     = 1'b1;
    bus_wen     = 1'b0;
    bus_add     = {24'h0, addr, 2'b00};
    bus_be      = be;
    bus_wdata   = data;
    test_mask_n = mask_n;
    wait_grant();
    bus_req     = 1'b0;
    test_mask_n = '0;
  endtask

  task automatic read_word(input bank_addr_t addr, input logic exp_s, input logic exp_m);
    exp_data   = model[addr];
    exp_single = exp_s;
    exp_multi  = exp_m;
    check_data = !exp_m;   // Data is meaningless on an uncorrectable word
    bus_req    = 1'b1;
    bus_wen    = 1'b1;
    bus_add    = {24'h0, addr, 2'b00};
    wait_grant();
    bus_req    = 1'b0;
    @(posedge clk);        // Response edge
    #1;
  endtask

  function automatic data_t merge_bytes(input data_t old_d, input data_t new_d, input be_t be);
    data_t res;
    res = old_d;
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) res[b*8 +: 8] = new_d[b*8 +: 8];
    end
    return res;
  endfunction

  function automatic code_t pick_flips(input int unsigned count);
    code_t flips;
    int unsigned pos;
    flips = '0;
    while ($countones(flips) < count) begin
      pos = $urandom_range(CodeWidth - 2, 0);   // Bit 38 does not invert with the data
      flips[pos] = 1'b1;
    end
    return flips;
  endfunction

  // Stored bits under a low mask take the inverted code, the model keeps the data
  task automatic inject_fault(input bank_addr_t addr, input code_t flips);
    write_word(addr, model[addr], '1, '0);
    write_word(addr, ~model[addr], '1, ~flips);
  endtask

  task automatic run_scrub_pass();
    repeat (BankWords) begin
      scrub_trigger = 1'b1;
      @(posedge clk);
      #1;
      scrub_trigger = 1'b0;
      while (scrub_state != IDLE) begin
        @(posedge clk);
        #1;
      end
    end
    @(posedge clk);        // Last pulse reaches the counters
    #1;
    scrub_check = 1'b1;
    @(posedge clk);
    #1;
    scrub_check = 1'b0;
  endtask

  initial begin : watchdog
    #(TimeoutCycles * 4);
    stop_with_failure("Timeout: the tests did not finish in the expected time");
  end

  initial begin : stimulus
    data_t d;
    be_t   be;
    bank_addr_t a;
    int unsigned gap;
    void'($urandom(32'h9b05_9743));
    {bus_req, bus_wen, bus_add, bus_be, bus_wdata} = '0;
    {scrub_trigger, scrub_check, check_data, exp_single, exp_multi} = '0;
    test_mask_n = '0;
    exp_data    = '0;
    exp_fix     = 0;
    exp_uncorr  = 0;
    for (int i = 0; i < BankWords; i++) model[i] = '0;
    test_name = "reset";
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    test_name = "full_write_read";
    for (int i = 0; i < 16; i++) begin
      d = $urandom;
      write_word(bank_addr_t'(i), d, '1, '0);
      model[i] = d;
    end
    for (int i = 0; i < 16; i++) read_word(bank_addr_t'(i), 1'b0, 1'b0);

    test_name = "partial_write";
    for (int i = 0; i < 8; i++) begin
      a  = bank_addr_t'($urandom_range(15, 0));
      d  = $urandom;
      be = be_t'($urandom_range(14, 0));
      write_word(a, d, be, '0);
      model[a] = merge_bytes(model[a], d, be);
      read_word(a, 1'b0, 1'b0);
    end

    test_name = "single_error";
    inject_fault(5, pick_flips(1));
    read_word(5, 1'b1, 1'b0);
    read_word(5, 1'b0, 1'b0);      // Clean after the write-back

    test_name = "double_error";
    model[45] = $urandom;
    inject_fault(45, pick_flips(2));
    read_word(45, 1'b0, 1'b1);

    test_name = "scrub_pass";
    model[20] = $urandom;
    inject_fault(20, pick_flips(1));
    inject_fault(45, pick_flips(2));
    exp_fix    = 1;
    exp_uncorr = 1;
    run_scrub_pass();
    read_word(20, 1'b0, 1'b0);
    read_word(45, 1'b0, 1'b1);

    test_name  = "scrub_with_reads";
    exp_uncorr = 2;
    fork
      run_scrub_pass();
      begin
        repeat (24) begin
          a = bank_addr_t'($urandom_range(15, 0));
          read_word(a, 1'b0, 1'b0);
          gap = $urandom_range(3, 0);
          repeat (gap) begin
            @(posedge clk);
            #1;
          end
        end
      end
    join

    $display("Done: no errors");
    $finish;
  end

endmodule

//--- filelist.f
rtl/ecc_sram_pkg.sv
rtl/ecc_sram_bank.sv
rtl/ecc_scrubber.sv
rtl/ecc_bus_adapter.sv
rtl/ecc_sram_top.sv
verification/ecc_sram_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the ECC SRAM testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=ecc_sram_sim

verilator --binary --assert -j 0 --top-module ecc_sram_tb -f filelist.f -o "$SIM"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
